// ==== source/soc_map_pkg.sv ====
package soc_map_pkg;

    // Data RAM at the bottom of the map
    localparam logic [31:0] ram_base = 32'h0000_0000;
    localparam int ram_words = 1024;
    localparam int ram_aw = $clog2(ram_words);

    // Boot ROM directly above the RAM
    localparam logic [31:0] rom_base = 32'h0000_1000;
    localparam int rom_words = 1024;
    localparam int rom_aw = $clog2(rom_words);

    // Single-register peripherals
    localparam logic [31:0] uart_addr = 32'h8000_0000;
    localparam logic [31:0] key_addr = 32'h8000_0010;

    // Core entry points
    localparam logic [31:0] reset_pc = rom_base;

    // Interrupt handler entry, inside the ROM image
    localparam logic [31:0] trap_vector = 32'h0000_1100;

    // Read value for holes in the map
    localparam logic [63:0] unmapped_data = 64'hDEADBEEF_DEADBEEF;

endpackage

// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int xlen = 64;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_opimm = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // MRET is matched as a whole word
    localparam logic [31:0] mret_word = {12'h302, 5'd0, 3'b000, 5'd0, op_system};

    // One instruction word, two field layouts
    typedef union packed {
        // I format, also sliced for the U and J immediates
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
        // S format for stores
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_view;
    } rv_instr_t;

endpackage

// ==== source/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if import rv_isa_pkg::*; ();

    logic [31:0]     addr;
    logic [xlen-1:0] wdata;
    logic            we;
    logic            re;
    logic [xlen-1:0] rdata;

    // Core side
    modport master (
        output addr, wdata, we, re,
        input  rdata
    );

    // Decoder side, answers rdata in the same cycle
    modport slave (
        input  addr, wdata, we, re,
        output rdata
    );

endinterface

// ==== source/irq_controller.sv ====
`timescale 1ns/1ps

module irq_controller (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       key_strobe,
    input  logic [7:0] key_code_in,
    input  logic       irq_ack,
    output logic       irq_req,
    output logic [7:0] key_code,
    output logic       led_irq
);

    assign led_irq = irq_req;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            irq_req <= 1'b0;
            key_code <= 8'h00;
        end else if (irq_ack) begin
            // A strobe in the acknowledge cycle is dropped
            irq_req <= 1'b0;
        end else if (key_strobe && (key_code_in != 8'h00)) begin
            irq_req <= 1'b1;
            key_code <= key_code_in;
        end
    end

    // Request only drops on the core's acknowledge
    req_held_until_ack: assert property (@(posedge clock) disable iff (!reset_n)
        $fell(irq_req) |-> $past(irq_ack));

endmodule

// ==== source/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder import soc_map_pkg::*, rv_isa_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  logic [31:0] fetch_addr,
    output logic [31:0] fetch_data,
    mem_bus_if.slave    bus,
    input  logic [7:0]  key_code,
    output logic [7:0]  uart_data,
    output logic        uart_write
);

    logic [31:0] rom [rom_words];
    logic [31:0] ram [ram_words];

    logic [31:0] f_rom_off;
    logic [31:0] f_ram_off;
    logic [31:0] d_rom_off;
    logic [31:0] d_ram_off;
    logic        f_rom_sel;
    logic        f_ram_sel;
    logic        d_rom_sel;
    logic        d_ram_sel;
    logic        key_sel;
    logic        uart_sel;

    initial $readmemh("rom.hex", rom);

    // Region hit when the offset from its base is inside its size
    assign f_rom_off = fetch_addr - rom_base;
    assign f_ram_off = fetch_addr - ram_base;
    assign d_rom_off = bus.addr - rom_base;
    assign d_ram_off = bus.addr - ram_base;
    assign f_rom_sel = f_rom_off < 32'(rom_words * 4);
    assign f_ram_sel = f_ram_off < 32'(ram_words * 4);
    assign d_rom_sel = d_rom_off < 32'(rom_words * 4);
    assign d_ram_sel = d_ram_off < 32'(ram_words * 4);
    assign key_sel = (bus.addr == key_addr);
    assign uart_sel = (bus.addr == uart_addr);

    // Instruction port
    always_comb begin
        if (f_rom_sel) begin
            fetch_data = rom[f_rom_off[rom_aw + 1:2]];
        end else if (f_ram_sel) begin
            fetch_data = ram[f_ram_off[ram_aw + 1:2]];
        end else begin
            fetch_data = unmapped_data[31:0];
        end
    end

    // Data read mux, memory words zero-extended
    always_comb begin
        if (key_sel) begin
            bus.rdata = {{(xlen - 8){1'b0}}, key_code};
        end else if (d_ram_sel) begin
            bus.rdata = {{(xlen - 32){1'b0}}, ram[d_ram_off[ram_aw + 1:2]]};
        end else if (d_rom_sel) begin
            bus.rdata = {{(xlen - 32){1'b0}}, rom[d_rom_off[rom_aw + 1:2]]};
        end else begin
            bus.rdata = unmapped_data;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.we && d_ram_sel) begin
            ram[d_ram_off[ram_aw + 1:2]] <= bus.wdata[31:0];
        end
    end

    // Output port, one pulse per store
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            uart_write <= 1'b0;
        end else begin
            uart_write <= bus.we && uart_sel;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.we && uart_sel) begin
            uart_data <= bus.wdata[7:0];
        end
    end

    uart_single_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        uart_write |=> !uart_write);

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, soc_map_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    output logic [31:0] fetch_addr,
    input  logic [31:0] fetch_data,
    mem_bus_if.master   bus,
    input  logic        irq_req,
    output logic        irq_ack,
    output logic [7:0]  ir_low,
    output logic        heartbeat
);

    logic [31:0]     pc;
    logic [31:0]     ir_pc;
    rv_instr_t       ir;
    logic            bubble;
    logic            in_handler;
    logic [31:0]     mepc;
    logic [xlen-1:0] regs [32];

    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] addr_sum;
    logic [xlen-1:0] rd_data;
    logic [31:0]     jal_target;
    logic            is_lui;
    logic            is_addi;
    logic            is_lw;
    logic            is_sw;
    logic            is_jal;
    logic            is_mret;
    logic            take_irq;
    logic            exec;
    logic            rd_we;

    assign fetch_addr = pc;
    assign ir_low = ir[7:0];

    // Operand reads, x0 always zero
    assign rs1_val = (ir.i_view.rs1 == 5'd0) ? '0 : regs[ir.i_view.rs1];
    assign rs2_val = (ir.s_view.rs2 == 5'd0) ? '0 : regs[ir.s_view.rs2];

    // Immediates, U and J rebuilt from I-view slices
    assign imm_i = {{(xlen - 12){ir.i_view.imm[11]}}, ir.i_view.imm};
    assign imm_s = {{(xlen - 12){ir.s_view.imm_hi[6]}}, ir.s_view.imm_hi, ir.s_view.imm_lo};
    assign imm_u = {{(xlen - 32){ir.i_view.imm[11]}}, ir.i_view.imm, ir.i_view.rs1,
                    ir.i_view.funct3, 12'b0};
    assign imm_j = {{(xlen - 21){ir.i_view.imm[11]}}, ir.i_view.imm[11], ir.i_view.rs1,
                    ir.i_view.funct3, ir.i_view.imm[0], ir.i_view.imm[10:1], 1'b0};

    assign is_lui = (ir.i_view.opcode == op_lui);
    assign is_addi = (ir.i_view.opcode == op_opimm) && (ir.i_view.funct3 == 3'b000);
    assign is_lw = (ir.i_view.opcode == op_load) && (ir.i_view.funct3 == 3'b010);
    assign is_sw = (ir.s_view.opcode == op_store) && (ir.s_view.funct3 == 3'b010);
    assign is_jal = (ir.i_view.opcode == op_jal);
    assign is_mret = (ir == mret_word);

    // Interrupt replaces the word in execute, which reruns after MRET
    assign take_irq = irq_req && !in_handler && !bubble;
    assign exec = !bubble && !take_irq;

    assign addr_sum = rs1_val + (is_sw ? imm_s : imm_i);
    assign jal_target = ir_pc + imm_j[31:0];

    // Data bus is driven straight from execute
    assign bus.addr = addr_sum[31:0];
    assign bus.wdata = rs2_val;
    assign bus.we = exec && is_sw;
    assign bus.re = exec && is_lw;

    always_comb begin
        rd_data = '0;
        if (is_lui) begin
            rd_data = imm_u;
        end else if (is_addi) begin
            rd_data = rs1_val + imm_i;
        end else if (is_lw) begin
            rd_data = {{(xlen - 32){bus.rdata[31]}}, bus.rdata[31:0]};
        end else if (is_jal) begin
            rd_data = {{(xlen - 32){1'b0}}, ir_pc + 32'd4};
        end
    end

    assign rd_we = exec && (ir.i_view.rd != 5'd0) && (is_lui || is_addi || is_lw || is_jal);

    always_ff @(posedge clock) begin
        if (rd_we) begin
            regs[ir.i_view.rd] <= rd_data;
        end
    end

    always_ff @(posedge clock) begin
        if (take_irq) begin
            mepc <= ir_pc;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc <= reset_pc;
            ir <= '0;
            ir_pc <= reset_pc;
            bubble <= 1'b1;
            in_handler <= 1'b0;
            irq_ack <= 1'b0;
            heartbeat <= 1'b0;
        end else begin
            heartbeat <= ~heartbeat;
            ir <= fetch_data;
            ir_pc <= pc;
            pc <= pc + 32'd4;
            bubble <= 1'b0;
            irq_ack <= take_irq;
            // Redirects flush the word fetched behind them
            if (take_irq) begin
                pc <= trap_vector;
                in_handler <= 1'b1;
                bubble <= 1'b1;
            end else if (exec && is_jal) begin
                pc <= jal_target;
                bubble <= 1'b1;
            end else if (exec && is_mret) begin
                pc <= mepc;
                in_handler <= 1'b0;
                bubble <= 1'b1;
            end
        end
    end

    ack_single_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        irq_ack |=> !irq_ack);

    no_read_with_write: assert property (@(posedge clock) disable iff (!reset_n)
        !(bus.we && bus.re));

endmodule

// ==== source/cpu_on_board.sv ====
`timescale 1ns/1ps

module cpu_on_board (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] key_code,
    input  logic       key_strobe,
    output logic [7:0] ledg,
    output logic       heartbeat,
    output logic       led_irq,
    output logic [7:0] uart_data,
    output logic       uart_write
);

    logic [31:0] fetch_addr;
    logic [31:0] fetch_data;
    logic        irq_req;
    logic        irq_ack;
    logic [7:0]  key_latched;

    mem_bus_if data_bus ();

    rv_core u_core (
        .clock      (CLOCK_50),
        .reset_n    (KEY0),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .bus        (data_bus),
        .irq_req    (irq_req),
        .irq_ack    (irq_ack),
        .ir_low     (ledg),
        .heartbeat  (heartbeat)
    );

    bus_decoder u_bus (
        .clock      (CLOCK_50),
        .reset_n    (KEY0),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .bus        (data_bus),
        .key_code   (key_latched),
        .uart_data  (uart_data),
        .uart_write (uart_write)
    );

    // Keyboard strobe in, latched code back to the bus
    irq_controller u_irq (
        .clock       (CLOCK_50),
        .reset_n     (KEY0),
        .key_strobe  (key_strobe),
        .key_code_in (key_code),
        .irq_ack     (irq_ack),
        .irq_req     (irq_req),
        .key_code    (key_latched),
        .led_irq     (led_irq)
    );

endmodule

// ==== test/tb_cpu_on_board.sv ====
`timescale 1ns/1ps

module tb_cpu_on_board;

    localparam int num_rows = 8;
    localparam int max_cycles = 2000 + 300 * num_rows;
    localparam int echo_wait = 300;
    localparam int silent_wait = 200;
    localparam int idle_cycles = 30;

    // Low byte of JAL x0 to itself, the idle spin
    localparam logic [7:0] idle_ir_low = 8'h6F;

    logic       CLOCK_50;
    logic       KEY0;
    logic [7:0] key_code;
    logic       key_strobe;
    logic [7:0] ledg;
    logic       heartbeat;
    logic       led_irq;
    logic [7:0] uart_data;
    logic       uart_write;

    // Stimulus table
    string      row_name [num_rows];
    logic [7:0] row_code [num_rows];
    bit         row_expect [num_rows];
    logic [7:0] row_echo [num_rows];

    logic [31:0] lfsr_state;
    logic [7:0]  code;
    int          errors;
    int          checks;
    int          cycle_count;
    string       cur_test;
    bit          expect_uart;
    bit          got_uart;
    logic [7:0]  got_data;
    logic        got_led;
    bit          hb_armed;
    logic        hb_prev;
    logic        s_uart;
    logic        s_led;
    logic        s_hb;
    logic [7:0]  s_ledg;
    bit          seen;

    cpu_on_board u_dut (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .key_code   (key_code),
        .key_strobe (key_strobe),
        .ledg       (ledg),
        .heartbeat  (heartbeat),
        .led_irq    (led_irq),
        .uart_data  (uart_data),
        .uart_write (uart_write)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: simulation ran past %0d cycles", max_cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected 0x%02h actual 0x%02h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, expected, actual);
        end
    endtask

    // Mid-cycle sample, all outputs settled
    task automatic sample_outputs();
        s_uart = uart_write;
        s_led = led_irq;
        s_hb = heartbeat;
        s_ledg = ledg;
        if (hb_armed) begin
            check_bit({cur_test, "/heartbeat"}, ~hb_prev, heartbeat);
        end
        hb_prev = heartbeat;
        got_uart = 1'b0;
        if (uart_write) begin
            if (expect_uart) begin
                got_uart = 1'b1;
                got_data = uart_data;
                got_led = led_irq;
            end else begin
                errors++;
                $display("Unexpected output write of 0x%02h during %s", uart_data, cur_test);
            end
        end
    endtask

    // Ends 1 ns after the next rising edge, where inputs change
    task automatic next_cycle();
        @(negedge CLOCK_50);
        sample_outputs();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic wait_for_output(input int limit, output bit seen_byte);
        int n;
        seen_byte = 1'b0;
        n = 0;
        expect_uart = 1'b1;
        while (!seen_byte && n < limit) begin
            next_cycle();
            seen_byte = got_uart;
            n++;
        end
        expect_uart = 1'b0;
        if (!seen_byte) begin
            errors++;
            $display("No output byte for %s within %0d cycles", cur_test, limit);
        end
    endtask

    // Quiet window on the idle loop, ledg alternates the JAL with its bubble
    task automatic idle_window(input int cycles);
        logic [7:0] shown;
        shown = 8'h00;
        repeat (cycles) begin
            next_cycle();
            // Holds the JAL byte once it has shown up
            if (shown !== idle_ir_low) begin
                shown = s_ledg;
            end
        end
        check_byte({cur_test, "/ledg"}, idle_ir_low, shown);
    endtask

    initial begin
        KEY0 = 1'b0;
        key_code = 8'h00;
        key_strobe = 1'b0;
        errors = 0;
        checks = 0;
        cycle_count = 0;
        expect_uart = 1'b0;
        got_uart = 1'b0;
        hb_armed = 1'b0;
        hb_prev = 1'b0;
        cur_test = "reset";

        row_name[0] = "key_41";
        row_code[0] = 8'h41;
        row_name[1] = "key_00";
        row_code[1] = 8'h00;
        row_name[2] = "key_7f";
        row_code[2] = 8'h7F;
        row_name[3] = "key_01";
        row_code[3] = 8'h01;
        lfsr_state = 32'h290ff60d;
        for (int r = 4; r < num_rows; r++) begin
            code = 8'h00;
            for (int b = 0; b < 8; b++) begin
                lfsr_state = lfsr_step(lfsr_state);
                code = {code[6:0], lfsr_state[0]};
            end
            row_name[r] = $sformatf("lfsr_%0d", r - 4);
            row_code[r] = (code == 8'h00) ? 8'h33 : code;
        end
        // Only nonzero codes raise an interrupt and get echoed
        for (int r = 0; r < num_rows; r++) begin
            row_expect[r] = (row_code[r] != 8'h00);
            row_echo[r] = row_code[r];
        end

        repeat (5) begin
            next_cycle();
            check_bit("reset/uart_write", 1'b0, s_uart);
            check_bit("reset/led_irq", 1'b0, s_led);
            check_bit("reset/heartbeat", 1'b0, s_hb);
        end
        KEY0 = 1'b1;
        cur_test = "after_reset";
        next_cycle();
        check_bit("after_reset/uart_write", 1'b0, s_uart);
        check_bit("after_reset/led_irq", 1'b0, s_led);
        check_bit("after_reset/heartbeat", 1'b0, s_hb);
        hb_armed = 1'b1;

        // Boot prints B, the incremented RAM value, newline
        cur_test = "boot_0";
        wait_for_output(100, seen);
        if (seen) check_byte(cur_test, 8'h42, got_data);
        cur_test = "boot_1";
        wait_for_output(100, seen);
        if (seen) check_byte(cur_test, 8'h5B, got_data);
        cur_test = "boot_2";
        wait_for_output(100, seen);
        if (seen) check_byte(cur_test, 8'h0A, got_data);
        cur_test = "boot_idle";
        idle_window(idle_cycles);

        for (int r = 0; r < num_rows; r++) begin
            cur_test = row_name[r];
            key_code = row_code[r];
            key_strobe = 1'b1;
            next_cycle();
            key_strobe = 1'b0;
            next_cycle();
            check_bit({cur_test, "/led_irq"}, row_expect[r], s_led);
            if (row_expect[r]) begin
                wait_for_output(echo_wait, seen);
                if (seen) begin
                    check_byte(cur_test, row_echo[r], got_data);
                    check_bit({cur_test, "/led_irq_at_echo"}, 1'b0, got_led);
                end
            end else begin
                repeat (silent_wait) begin
                    next_cycle();
                    check_bit({cur_test, "/led_irq_quiet"}, 1'b0, s_led);
                end
            end
            // Any write here means MRET did not reach the idle loop
            cur_test = {row_name[r], "_idle"};
            idle_window(idle_cycles);
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== rom.hex ====
// Boot ROM image, one 32-bit instruction word per line in hex
// First line is rom_base, @40 jumps to the word at trap_vector
800000B7
05A00113
00202823
01002183
00118193
04200213
0040A023
00A00293
0030A023
00000013
0050A023
0000006F
// Interrupt handler, reads key_addr and echoes it to the output port
@40
80000337
01032403
00832023
30200073

// ==== src.f ====
source/soc_map_pkg.sv
source/rv_isa_pkg.sv
source/mem_bus_if.sv
source/irq_controller.sv
source/bus_decoder.sv
source/rv_core.sv
source/cpu_on_board.sv
test/tb_cpu_on_board.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_cpu_on_board -f src.f -o sim_cpu_on_board

./obj_dir/sim_cpu_on_board > sim.log 2>&1
cat sim.log

if grep -q "=== PASS ===" sim.log; then
    exit 0
else
    exit 1
fi
